/* list.f */
design/histPkg.sv
design/dataFormatter.sv
design/binCounter.sv
design/peakDetector.sv
design/histControl.sv
design/histogramTop.sv
verification/histogramTb.sv

/* run.sh */
#!/bin/bash
# build and run the histogram testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module histogramTb -o histogramSim &&
    ./obj_dir/histogramSim > sim.log 2>&1
[ -f sim.log ] && cat sim.log
# fail message anywhere in the log means failure
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

/* verification/histogramTb.sv */
module histogramTb;

    typedef logic [histPkg::sampleWidth-1:0] sampleT;

    localparam int measureCount = 6;
    // six measurements of two ~150 cycle passes, doubled, rounded up
    localparam int cycleLimit = 4000;
    localparam int countLimit = (1 << histPkg::countWidth) - 1;
    localparam int windowSpan = histPkg::binCount << histPkg::fineShift;
    // late samples sent after each pass
    localparam int extraCount = 6;

    logic                              clk;
    logic                              arstN;
    sampleT                            sample;
    logic                              sampleValid;
    logic                              coarseValid;
    logic [histPkg::binIndexWidth-1:0] coarsePeak;
    logic                              resultValid;
    logic [histPkg::binIndexWidth-1:0] finePeak;
    sampleT                            resultTime;

    logic [15:0] lfsrState = 16'd9;
    sampleT      passBuf [histPkg::acqLength];
    int          expCoarseQ[$];
    int          expFineQ[$];
    int          expTimeQ[$];
    int          checksDone = 0;
    int          cycleCount = 0;

    histogramTop dut0 (
        .clk(clk),
        .arstN(arstN),
        .sample(sample),
        .sampleValid(sampleValid),
        .coarseValid(coarseValid),
        .coarsePeak(coarsePeak),
        .resultValid(resultValid),
        .finePeak(finePeak),
        .resultTime(resultTime)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one lfsr step per bit
    function automatic int randBits(input int n);
        int r;
        int k;
        r = 0;
        for (k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);
            r = (r << 1) | int'(lfsrState[0]);
        end
        return r;
    endfunction

    // bins one pass with saturation, lowest index wins a tie
    function automatic int histogramModel(input sampleT samples [histPkg::acqLength],
                                          input bit fine, input sampleT base);
        int     counts [histPkg::binCount];
        sampleT offset;
        int     bin;
        int     best;
        int     i;
        for (i = 0; i < histPkg::binCount; i++) begin
            counts[i] = 0;
        end
        for (i = 0; i < histPkg::acqLength; i++) begin
            bin = -1;
            if (fine) begin
                // modulo subtraction, values below base wrap far out
                offset = samples[i] - base;
                if (int'(offset) < windowSpan) begin
                    bin = int'(offset) >> histPkg::fineShift;
                end
            end else begin
                bin = int'(samples[i]) >> histPkg::coarseShift;
            end
            if (bin >= 0 && counts[bin] < countLimit) begin
                counts[bin]++;
            end
        end
        best = 0;
        for (i = 1; i < histPkg::binCount; i++) begin
            if (counts[i] > counts[best]) begin
                best = i;
            end
        end
        return best;
    endfunction

    task automatic checkValue(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("ERROR at time %0t: %s mismatch, expected %0d, got %0d",
                     $time, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic driveSample(input sampleT v);
        @(posedge clk);
        #5;
        sample      = v;
        sampleValid = 1'b1;
    endtask

    // mode 0 biased coarse, 1 tie at saturation, 2 fine around the window
    task automatic fillPass(input int mode, input int fav, input sampleT base);
        int i;
        for (i = 0; i < histPkg::acqLength; i++) begin
            if (mode == 1) begin
                // 65 for bin 9, 63 for bin 2
                passBuf[i] = sampleT'(((i < 65 ? 9 : 2) << histPkg::coarseShift) | randBits(6));
            end else if (mode == 2) begin
                if (randBits(1) == 1) begin
                    passBuf[i] = sampleT'(int'(base) + (fav << histPkg::fineShift) + randBits(2));
                end else begin
                    // spread from below the window to well past its end
                    passBuf[i] = sampleT'(int'(base) - 16 + randBits(7));
                end
            end else if (randBits(2) != 0) begin
                passBuf[i] = sampleT'((fav << histPkg::coarseShift) | randBits(6));
            end else begin
                passBuf[i] = sampleT'(randBits(10));
            end
        end
    endtask

    task automatic runPass(input bit fine, input sampleT base, input int dropBin,
                           output int peak);
        int i;
        peak = histogramModel(passBuf, fine, base);
        if (fine) begin
            expFineQ.push_back(peak);
            expTimeQ.push_back(int'(sampleT'(int'(base) + (peak << histPkg::fineShift) + 2)));
        end else begin
            expCoarseQ.push_back(peak);
        end
        for (i = 0; i < histPkg::acqLength; i++) begin
            driveSample(passBuf[i]);
        end
        // late samples into another bin, must not count
        for (i = 0; i < extraCount; i++) begin
            if (fine) begin
                driveSample(sampleT'(int'(base) + (dropBin << histPkg::fineShift) + randBits(2)));
            end else begin
                driveSample(sampleT'((dropBin << histPkg::coarseShift) | randBits(6)));
            end
        end
        @(posedge clk);
        #5;
        sampleValid = 1'b0;
        @(negedge clk);
        while (!(fine ? resultValid : coarseValid)) begin
            @(negedge clk);
        end
    endtask

    // strobes compared mid-cycle against the queued model results
    always @(negedge clk) begin
        if (coarseValid && expCoarseQ.size() == 0) begin
            $display("coarseValid strobe arrived with no coarse pass outstanding");
            $display("TEST FAILED");
            $fatal(1, "unexpected coarse strobe");
        end else if (coarseValid) begin
            checkValue(int'(coarsePeak), expCoarseQ.pop_front(), "coarsePeak");
            checksDone++;
        end else if (resultValid && expFineQ.size() == 0) begin
            $display("resultValid strobe arrived with no fine pass outstanding");
            $display("TEST FAILED");
            $fatal(1, "unexpected result strobe");
        end else if (resultValid) begin
            checkValue(int'(finePeak), expFineQ.pop_front(), "finePeak");
            checkValue(int'(resultTime), expTimeQ.pop_front(), "resultTime");
            checksDone++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: a coarseValid or resultValid strobe never came in %0d cycles",
                     cycleLimit);
            $display("TEST FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    initial begin
        int     m;
        int     fav;
        int     coarseWin;
        int     fineWin;
        sampleT base;
        sample      = '0;
        sampleValid = 1'b0;
        arstN       = 1'b0;
        repeat (4) @(posedge clk);
        #5;
        arstN = 1'b1;
        // back to back measurements, counters must clear in between
        for (m = 0; m < measureCount; m++) begin
            if (m == 1) begin
                fav = 2;
                fillPass(1, fav, '0);
            end else begin
                fav = (m == 0) ? 5 : randBits(4);
                fillPass(0, fav, '0);
            end
            runPass(1'b0, '0, (fav + 8) % histPkg::binCount, coarseWin);
            if (m == 1) begin
                checkValue(coarseWin, 2, "reference tie winner");
            end
            base = sampleT'(coarseWin << histPkg::coarseShift);
            fav = randBits(4);
            fillPass(2, fav, base);
            runPass(1'b1, base, (fav + 8) % histPkg::binCount, fineWin);
        end
        // let the checker see the last strobe
        repeat (2) @(negedge clk);
        if (checksDone == measureCount * 2) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d strobes were checked", checksDone, measureCount * 2);
            $display("TEST FAILED");
            $fatal(1, "missing strobes");
        end
    end

endmodule

/* design/histogramTop.sv */
module histogramTop (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic [histPkg::sampleWidth-1:0]     sample,
    input  logic                                sampleValid,
    output logic                                coarseValid,
    output logic [histPkg::binIndexWidth-1:0]   coarsePeak,
    output logic                                resultValid,
    output logic [histPkg::binIndexWidth-1:0]   finePeak,
    output logic [histPkg::sampleWidth-1:0]     resultTime
);

    logic                                              sampleAccept;
    logic                                              hisNum;
    logic [histPkg::sampleWidth-1:0]                   windowBase;
    logic                                              clearBins;
    logic                                              scanStart;
    logic                                              peakDone;
    logic [histPkg::binIndexWidth-1:0]                 peakIndex;
    logic [histPkg::binCount-1:0]                      binHit;
    logic [histPkg::binCount*histPkg::countWidth-1:0]  counts;

    histControl histControlU0 (
        .clk(clk),
        .arstN(arstN),
        .sampleValid(sampleValid),
        .sampleAccept(sampleAccept),
        .hisNum(hisNum),
        .windowBase(windowBase),
        .clearBins(clearBins),
        .scanStart(scanStart),
        .peakDone(peakDone),
        .peakIndex(peakIndex),
        .coarseValid(coarseValid),
        .coarsePeak(coarsePeak),
        .resultValid(resultValid),
        .finePeak(finePeak),
        .resultTime(resultTime)
    );

    dataFormatter dataFormatterU0 (
        .clk(clk),
        .arstN(arstN),
        .sample(sample),
        .sampleAccept(sampleAccept),
        .hisNum(hisNum),
        .windowBase(windowBase),
        .binHit(binHit)
    );

    // one counter per bin, shared between both passes
    for (genvar i = 0; i < histPkg::binCount; i++) begin : genBins
        binCounter binCounterU (
            .clk(clk),
            .arstN(arstN),
            .hit(binHit[i]),
            .clear(clearBins),
            .count(counts[i*histPkg::countWidth +: histPkg::countWidth])
        );
    end

    peakDetector peakDetectorU0 (
        .clk(clk),
        .arstN(arstN),
        .scanStart(scanStart),
        .counts(counts),
        .peakDone(peakDone),
        .peakIndex(peakIndex)
    );

endmodule

/* design/histControl.sv */
module histControl (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                sampleValid,
    output logic                                sampleAccept,
    output logic                                hisNum,
    output logic [histPkg::sampleWidth-1:0]     windowBase,
    output logic                                clearBins,
    output logic                                scanStart,
    input  logic                                peakDone,
    input  logic [histPkg::binIndexWidth-1:0]   peakIndex,
    output logic                                coarseValid,
    output logic [histPkg::binIndexWidth-1:0]   coarsePeak,
    output logic                                resultValid,
    output logic [histPkg::binIndexWidth-1:0]   finePeak,
    output logic [histPkg::sampleWidth-1:0]     resultTime
);

    typedef enum logic [1:0] {
        stAcquire,
        stDrain,
        stScan
    } stateT;

    stateT                               state;
    logic [histPkg::acqCountWidth-1:0]   acqCount;
    logic [histPkg::drainCountWidth-1:0] drainCount;
    logic [histPkg::sampleWidth-1:0]     fineOffset;
    logic                                lastSample;
    logic                                drainDone;

    // samples only count while acquiring, the rest are dropped
    assign sampleAccept = sampleValid && (state == stAcquire);
    assign lastSample   = (acqCount == histPkg::acqCountWidth'(histPkg::acqLength - 1));
    assign drainDone    = (drainCount == histPkg::drainCountWidth'(histPkg::drainCycles - 1));

    // empty the counters as soon as the peak is known
    assign clearBins = peakDone && (state == stScan);

    // fine peak scaled back to timestamp units
    assign fineOffset = {{(histPkg::sampleWidth - histPkg::binIndexWidth - histPkg::fineShift){1'b0}},
                         peakIndex,
                         {histPkg::fineShift{1'b0}}};

    // pass sequencing
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state       <= stAcquire;
            acqCount    <= '0;
            drainCount  <= '0;
            scanStart   <= 1'b0;
            hisNum      <= 1'b0;
            windowBase  <= '0;
            coarseValid <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            scanStart   <= 1'b0;
            coarseValid <= 1'b0;
            resultValid <= 1'b0;
            case (state)
                stAcquire: begin
                    if (sampleAccept) begin
                        if (lastSample) begin
                            acqCount   <= '0;
                            drainCount <= '0;
                            state      <= stDrain;
                        end else begin
                            acqCount <= acqCount + 1'b1;
                        end
                    end
                end
                stDrain: begin
                    // last hit still on its way into the counters
                    if (drainDone) begin
                        scanStart <= 1'b1;
                        state     <= stScan;
                    end else begin
                        drainCount <= drainCount + 1'b1;
                    end
                end
                stScan: begin
                    if (peakDone) begin
                        hisNum <= ~hisNum;
                        state  <= stAcquire;
                        if (!hisNum) begin
                            // coarse peak sets the fine window
                            coarseValid <= 1'b1;
                            windowBase  <= {peakIndex, {histPkg::coarseShift{1'b0}}};
                        end else begin
                            resultValid <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= stAcquire;
                end
            endcase
        end
    end

    // result payload, qualified by the strobes
    always_ff @(posedge clk) begin
        if (state == stScan && peakDone) begin
            if (!hisNum) begin
                coarsePeak <= peakIndex;
            end else begin
                finePeak   <= peakIndex;
                // window base plus bin offset, centred in the bin
                resultTime <= windowBase + fineOffset + histPkg::fineCenter;
            end
        end
    end

    // detector only answers a scan that control started
    assert property (@(posedge clk) disable iff (!arstN)
        peakDone |-> (state == stScan));

endmodule

/* design/peakDetector.sv */
module peakDetector (
    input  logic                                                 clk,
    input  logic                                                 arstN,
    input  logic                                                 scanStart,
    input  logic [histPkg::binCount*histPkg::countWidth-1:0]     counts,
    output logic                                                 peakDone,
    output logic [histPkg::binIndexWidth-1:0]                    peakIndex
);

    logic                              busy;
    logic [histPkg::binIndexWidth-1:0] scanIndex;
    logic [histPkg::binIndexWidth-1:0] bestIndex;
    logic [histPkg::binIndexWidth-1:0] nextBest;
    logic [histPkg::countWidth-1:0]    maxCount;
    logic [histPkg::countWidth-1:0]    curCount;
    logic                              newMax;
    logic                              lastBin;

    // count under the scan pointer
    assign curCount = counts[scanIndex*histPkg::countWidth +: histPkg::countWidth];

    // strictly greater only, so ties keep the lower bin
    assign newMax   = curCount > maxCount;
    assign nextBest = newMax ? scanIndex : bestIndex;
    assign lastBin  = (scanIndex == histPkg::binIndexWidth'(histPkg::binCount - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy      <= 1'b0;
            scanIndex <= '0;
            bestIndex <= '0;
            maxCount  <= '0;
            peakDone  <= 1'b0;
            peakIndex <= '0;
        end else begin
            peakDone <= 1'b0;
            if (scanStart) begin
                // empty histogram reports bin 0
                busy      <= 1'b1;
                scanIndex <= '0;
                bestIndex <= '0;
                maxCount  <= '0;
            end else if (busy) begin
                if (newMax) begin
                    maxCount <= curCount;
                end
                bestIndex <= nextBest;
                scanIndex <= scanIndex + 1'b1;
                if (lastBin) begin
                    // final compare folded straight into the result
                    busy      <= 1'b0;
                    peakDone  <= 1'b1;
                    peakIndex <= nextBest;
                end
            end
        end
    end

    // control must not restart a scan before the previous one finished
    assert property (@(posedge clk) disable iff (!arstN) scanStart |-> !busy);

endmodule

/* design/binCounter.sv */
module binCounter (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             hit,
    input  logic                             clear,
    output logic [histPkg::countWidth-1:0]   count
);

    logic atMax;

    // saturation point
    assign atMax = (count == histPkg::countMax);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (clear) begin
            // new pass starts from empty
            count <= '0;
        end else if (hit && !atMax) begin
            count <= count + 1'b1;
        end
    end

    // clear comes at the end of a scan, when no sample can be in flight
    assert property (@(posedge clk) disable iff (!arstN) !(hit && clear));

endmodule

/* design/dataFormatter.sv */
module dataFormatter (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic [histPkg::sampleWidth-1:0]     sample,
    input  logic                                sampleAccept,
    input  logic                                hisNum,
    input  logic [histPkg::sampleWidth-1:0]     windowBase,
    output logic [histPkg::binCount-1:0]        binHit
);

    logic [histPkg::sampleWidth-1:0]   offset;
    logic [histPkg::binIndexWidth-1:0] coarseBin;
    logic [histPkg::binIndexWidth-1:0] fineBin;
    logic [histPkg::binIndexWidth-1:0] hitBin;
    logic                              inWindow;
    logic                              hitValid;

    // coarse bin is just the top bits of the timestamp
    assign coarseBin = sample[histPkg::coarseShift +: histPkg::binIndexWidth];

    // offset into the fine window
    // below windowBase it wraps to a large value, so it falls out of range
    assign offset   = sample - windowBase;
    assign fineBin  = offset[histPkg::fineShift +: histPkg::binIndexWidth];
    assign inWindow = (offset >> (histPkg::fineShift + histPkg::binIndexWidth)) == '0;

    // pick the bin for the current pass
    always_comb begin
        if (hisNum) begin
            hitBin   = fineBin;
            hitValid = inWindow;
        end else begin
            hitBin   = coarseBin;
            hitValid = 1'b1;
        end
    end

    // one registered hit per accepted sample
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            binHit <= '0;
        end else begin
            binHit <= '0;
            if (sampleAccept && hitValid) begin
                binHit[hitBin] <= 1'b1;
            end
        end
    end

    // fine window always starts on a coarse bin boundary
    assert property (@(posedge clk) disable iff (!arstN)
        windowBase[histPkg::coarseShift-1:0] == '0);

endmodule

/* design/histPkg.sv */
package histPkg;

    // rough timestamp width
    localparam int sampleWidth = 10;

    // bins per pass, same count for coarse and fine
    localparam int binCount = 16;
    localparam int binIndexWidth = $clog2(binCount);

    // per-bin counter, sticks at all ones
    localparam int countWidth = 6;
    localparam logic [countWidth-1:0] countMax = '1;

    // accepted samples that make up one pass
    localparam int acqLength = 128;
    localparam int acqCountWidth = $clog2(acqLength);

    // coarse bin is sample >> coarseShift
    localparam int coarseShift = 6;
    // fine bin is (sample - windowBase) >> fineShift
    localparam int fineShift = 2;
    // centre of one fine bin, added to the reported time
    localparam logic [sampleWidth-1:0] fineCenter = sampleWidth'(1 << (fineShift - 1));

    // settle time for the last hit before the scan
    localparam int drainCycles = 2;
    localparam int drainCountWidth = $clog2(drainCycles + 1);

endpackage
